// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axis_bypass
RTL_TOP   ?= axis_bypass_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
rtl/axis_stream_pkg.sv
rtl/axis_ctrl_pkg.sv
rtl/axis_skid_buffer.sv
rtl/axis_reg_slice.sv
rtl/axis_tlast_advance.sv
rtl/axis_path_ctrl.sv
rtl/axis_bypass_top.sv
bench/axis_bypass_properties.sv
bench/tb_axis_bypass.sv

// ==== bench/axis_bypass_properties.sv ====
// Handshake and reset properties for the bypass stream top level
`timescale 1ns/1ps

module axis_bypass_properties (
    input logic                          axi4s_if_from_tx,
    input logic                          aresetn,
    input logic                          bypass,
    input logic                          in_tvalid,
    input logic                          in_tready,
    input axis_stream_pkg::stream_beat_t out_beat,
    input logic                          out_tvalid,
    input logic                          out_tready,
    input axis_ctrl_pkg::path_sel_t      sel
);

    logic same_path;
    logic in_stall;

    // A pending path change legitimately stalls the input while both paths drain
    assign same_path = (bypass == (sel == axis_ctrl_pkg::path_bypass));
    assign in_stall  = in_tvalid && out_tready && !in_tready && same_path;

    a_out_stable: assert property (@(posedge axi4s_if_from_tx) disable iff (!aresetn)
        out_tvalid && !out_tready |=> $stable(out_beat))
        else $error("out_beat changed while stalled");

    a_reset_quiet: assert property (@(posedge axi4s_if_from_tx)
        !aresetn |-> !out_tvalid)
        else $error("out_tvalid high during reset");

    a_ready_recovers: assert property (@(posedge axi4s_if_from_tx) disable iff (!aresetn)
        in_stall [*2] |=> !in_stall)
        else $error("in_tready low for more than two cycles with output ready");

endmodule : axis_bypass_properties

bind axis_bypass_top axis_bypass_properties u_props (
    .axi4s_if_from_tx (axi4s_if_from_tx),
    .aresetn          (aresetn),
    .bypass           (bypass),
    .in_tvalid        (in_tvalid),
    .in_tready        (in_tready),
    .out_beat         (out_beat),
    .out_tvalid       (out_tvalid),
    .out_tready       (out_tready),
    .sel              (u_ctrl.sel_q)
);

// ==== bench/tb_axis_bypass.sv ====
// Directed testbench for the bypass stream path with block-mode tlast advance
`timescale 1ns/1ps

module tb_axis_bypass;

    localparam int max_stall = 6;

    logic                          axi4s_if_from_tx;
    logic                          aresetn;
    logic                          bypass;
    axis_stream_pkg::stream_beat_t in_beat;
    logic                          in_tvalid;
    logic                          in_tready;
    axis_stream_pkg::stream_beat_t out_beat;
    logic                          out_tvalid;
    logic                          out_tready;

    axis_stream_pkg::stream_beat_t send_q[$];
    axis_stream_pkg::stream_beat_t exp_q[$];
    axis_stream_pkg::stream_beat_t got_q[$];
    bit                            byp_q[$];

    logic [31:0] rng_state = 32'h15fa;
    int          cycle_cnt = 0;
    int          deadline  = 200;
    int          errors    = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          test_err_start;

    axis_bypass_top UUT (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .bypass           (bypass),
        .in_beat          (in_beat),
        .in_tvalid        (in_tvalid),
        .in_tready        (in_tready),
        .out_beat         (out_beat),
        .out_tvalid       (out_tvalid),
        .out_tready       (out_tready)
    );

    initial begin
        axi4s_if_from_tx = 1'b0;
        forever #2 axi4s_if_from_tx = ~axi4s_if_from_tx;
    end

    // Watchdog deadline moves with each stream run
    always @(posedge axi4s_if_from_tx) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > deadline) begin
            $display("Timeout: DUT stopped delivering beats at cycle %0d", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // ==================================================
    // Stimulus and reference model
    // ==================================================

    task automatic add_packet(input int len, input bit zero_tail, input bit mode,
                              input bit new_mode, input int switch_at);
        axis_stream_pkg::stream_beat_t pkt[$];
        axis_stream_pkg::stream_beat_t b;
        logic [31:0]                   r;
        for (int i = 0; i < len; i++) begin
            r       = rand32();
            b.tdata = {rand32(), rand32()};
            b.tkeep = r[7:0] | 8'h01;
            b.tlast = (i == len - 1);
            if (b.tlast && zero_tail) begin
                b.tkeep = '0;
            end
            pkt.push_back(b);
            send_q.push_back(b);
            byp_q.push_back((i >= switch_at) ? new_mode : mode);
        end
        // Block mode drops an empty tail beat behind a real one
        if (!mode && len >= 2 && pkt[len-1].tkeep == '0) begin
            pkt[len-2].tlast = 1'b1;
            void'(pkt.pop_back());
        end
        foreach (pkt[i]) begin
            exp_q.push_back(pkt[i]);
        end
    endtask

    task automatic run_stream(input bit rand_ready);
        int          sent;
        int          stall;
        logic [31:0] r;
        sent  = 0;
        stall = 0;
        got_q.delete();
        deadline = cycle_cnt + send_q.size() * (max_stall + 4) + 100;
        while (sent < send_q.size() || got_q.size() < exp_q.size()) begin
            @(posedge axi4s_if_from_tx);
            #1;
            if (sent < send_q.size()) begin
                in_beat   = send_q[sent];
                in_tvalid = 1'b1;
                bypass    = byp_q[sent];
            end else begin
                in_tvalid = 1'b0;
            end
            r          = rand32();
            out_tready = !rand_ready || r[0] || (stall >= max_stall - 1);
            stall      = out_tready ? 0 : stall + 1;
            @(negedge axi4s_if_from_tx);
            if (in_tvalid && in_tready) begin
                sent++;
            end
            if (out_tvalid && out_tready) begin
                got_q.push_back(out_beat);
            end
        end
        @(posedge axi4s_if_from_tx);
        #1;
        in_tvalid  = 1'b0;
        out_tready = 1'b1;
        // Nothing may follow the expected beats
        repeat (5) begin
            @(negedge axi4s_if_from_tx);
            if (out_tvalid) begin
                $display("Extra output beat at %0t after the stream ended", $time);
                errors++;
            end
        end
    endtask

    task automatic check_results();
        if (got_q.size() != exp_q.size()) begin
            $display("CHECK FAILED at %0t: out_beat count got %0d expected %0d",
                     $time, got_q.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            if (got_q[i] != exp_q[i]) begin
                $display("CHECK FAILED at %0t: out_beat[%0d] got %h/%h/%b expected %h/%h/%b",
                         $time, i, got_q[i].tdata, got_q[i].tkeep, got_q[i].tlast,
                         exp_q[i].tdata, exp_q[i].tkeep, exp_q[i].tlast);
                errors++;
            end
        end
        send_q.delete();
        exp_q.delete();
        byp_q.delete();
    endtask

    task automatic start_test();
        test_err_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err_start) begin
            tests_bad++;
        end
        $display("Test %0d %s: %s", tests_run, name,
                 (errors == test_err_start) ? "ok" : "errors");
    endtask

    // ==================================================
    // Directed tests
    // ==================================================

    task automatic test_reset_idle();
        start_test();
        aresetn = 1'b0;
        repeat (3) begin
            @(posedge axi4s_if_from_tx);
            #1;
            if (out_tvalid !== 1'b0) begin
                $display("CHECK FAILED at %0t: out_tvalid got %b expected 0", $time, out_tvalid);
                errors++;
            end
        end
        aresetn = 1'b1;
        repeat (10) begin
            @(negedge axi4s_if_from_tx);
            if (out_tvalid !== 1'b0) begin
                $display("CHECK FAILED at %0t: out_tvalid got %b expected 0", $time, out_tvalid);
                errors++;
            end
        end
        end_test("reset and idle");
    endtask

    task automatic test_bypass_random();
        logic [31:0] r;
        start_test();
        for (int p = 0; p < 6; p++) begin
            r = rand32();
            add_packet(int'(r[2:0] % 5) + 1, r[3], 1'b1, 1'b1, 99);
        end
        run_stream(1'b0);
        check_results();
        end_test("bypass pass-through");
    endtask

    task automatic test_block_tail();
        start_test();
        add_packet(3, 1'b1, 1'b0, 1'b0, 99);
        add_packet(2, 1'b1, 1'b0, 1'b0, 99);
        add_packet(4, 1'b0, 1'b0, 1'b0, 99);
        add_packet(1, 1'b0, 1'b0, 1'b0, 99);
        add_packet(5, 1'b1, 1'b0, 1'b0, 99);
        run_stream(1'b0);
        check_results();
        end_test("block tail removal");
    endtask

    task automatic test_block_single();
        start_test();
        add_packet(1, 1'b1, 1'b0, 1'b0, 99);
        add_packet(1, 1'b1, 1'b0, 1'b0, 99);
        run_stream(1'b0);
        check_results();
        end_test("block single empty beat");
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        start_test();
        for (int m = 0; m < 2; m++) begin
            for (int p = 0; p < 8; p++) begin
                r = rand32();
                add_packet(int'(r[2:0] % 5) + 1, r[3], m[0], m[0], 99);
            end
            run_stream(1'b1);
            check_results();
        end
        end_test("random back-pressure");
    endtask

    // Request level must still hold when the next first beat reaches the boundary
    task automatic test_mid_toggle();
        start_test();
        add_packet(4, 1'b1, 1'b0, 1'b1, 2);
        add_packet(3, 1'b1, 1'b1, 1'b0, 2);
        add_packet(3, 1'b1, 1'b0, 1'b0, 99);
        run_stream(1'b0);
        check_results();
        end_test("bypass toggle mid-packet");
    endtask

    initial begin
        aresetn    = 1'b0;
        bypass     = 1'b0;
        in_beat    = '0;
        in_tvalid  = 1'b0;
        out_tready = 1'b1;
        test_reset_idle();
        test_bypass_random();
        test_block_tail();
        test_block_single();
        test_backpressure();
        test_mid_toggle();
        $display("Summary: %0d tests, %0d with errors, %0d check errors",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_axis_bypass

// ==== rtl/axis_bypass_top.sv ====
// AXI4-Stream path with input skid buffer, tlast-advance block and bypass slice
`timescale 1ns/1ps

module axis_bypass_top (
    input  logic                          axi4s_if_from_tx,
    input  logic                          aresetn,
    input  logic                          bypass,
    input  axis_stream_pkg::stream_beat_t in_beat,
    input  logic                          in_tvalid,
    output logic                          in_tready,
    output axis_stream_pkg::stream_beat_t out_beat,
    output logic                          out_tvalid,
    input  logic                          out_tready
);

    axis_stream_pkg::stream_beat_t skid_beat;
    logic                          skid_tvalid;
    logic                          skid_tready;

    axis_stream_pkg::stream_beat_t blk_beat;
    logic                          blk_tvalid;
    logic                          blk_tready;
    axis_stream_pkg::stream_beat_t byp_beat;
    logic                          byp_tvalid;
    logic                          byp_tready;

    axis_stream_pkg::stream_beat_t blk_ret_beat;
    logic                          blk_ret_tvalid;
    logic                          blk_ret_tready;
    axis_stream_pkg::stream_beat_t byp_ret_beat;
    logic                          byp_ret_tvalid;
    logic                          byp_ret_tready;
    logic                          blk_busy;

    axis_skid_buffer u_skid (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_beat          (in_beat),
        .in_tvalid        (in_tvalid),
        .in_tready        (in_tready),
        .out_beat         (skid_beat),
        .out_tvalid       (skid_tvalid),
        .out_tready       (skid_tready)
    );

    axis_path_ctrl u_ctrl (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .bypass           (bypass),
        .in_beat          (skid_beat),
        .in_tvalid        (skid_tvalid),
        .in_tready        (skid_tready),
        .blk_beat         (blk_beat),
        .blk_tvalid       (blk_tvalid),
        .blk_tready       (blk_tready),
        .byp_beat         (byp_beat),
        .byp_tvalid       (byp_tvalid),
        .byp_tready       (byp_tready),
        .blk_ret_beat     (blk_ret_beat),
        .blk_ret_tvalid   (blk_ret_tvalid),
        .blk_ret_tready   (blk_ret_tready),
        .byp_ret_beat     (byp_ret_beat),
        .byp_ret_tvalid   (byp_ret_tvalid),
        .byp_ret_tready   (byp_ret_tready),
        .blk_busy         (blk_busy),
        .out_beat         (out_beat),
        .out_tvalid       (out_tvalid),
        .out_tready       (out_tready)
    );

    // Block path
    axis_tlast_advance u_adv (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_beat          (blk_beat),
        .in_tvalid        (blk_tvalid),
        .in_tready        (blk_tready),
        .out_beat         (blk_ret_beat),
        .out_tvalid       (blk_ret_tvalid),
        .out_tready       (blk_ret_tready),
        .busy             (blk_busy)
    );

    // Bypass path, one register stage
    axis_reg_slice u_byp (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_beat          (byp_beat),
        .in_tvalid        (byp_tvalid),
        .in_tready        (byp_tready),
        .out_beat         (byp_ret_beat),
        .out_tvalid       (byp_ret_tvalid),
        .out_tready       (byp_ret_tready)
    );

endmodule : axis_bypass_top

// ==== rtl/axis_ctrl_pkg.sv ====
// Path selection and control FSM encodings for the bypass datapath
package axis_ctrl_pkg;

    // Datapath currently carrying packets
    typedef enum logic {
        path_block  = 1'b0,
        path_bypass = 1'b1
    } path_sel_t;

    // Packet boundary tracking
    typedef enum logic [1:0] {
        st_idle   = 2'd0,  // boundary, both paths empty
        st_packet = 2'd1,  // mid-packet on current path
        st_drain  = 2'd2   // boundary, paths may still hold beats
    } ctrl_state_t;

endpackage : axis_ctrl_pkg

// ==== rtl/axis_path_ctrl.sv ====
// Packet-boundary path selection and valid/ready steering between block and bypass
`timescale 1ns/1ps

module axis_path_ctrl (
    input  logic                          axi4s_if_from_tx,
    input  logic                          aresetn,
    input  logic                          bypass,
    input  axis_stream_pkg::stream_beat_t in_beat,
    input  logic                          in_tvalid,
    output logic                          in_tready,
    output axis_stream_pkg::stream_beat_t blk_beat,
    output logic                          blk_tvalid,
    input  logic                          blk_tready,
    output axis_stream_pkg::stream_beat_t byp_beat,
    output logic                          byp_tvalid,
    input  logic                          byp_tready,
    input  axis_stream_pkg::stream_beat_t blk_ret_beat,
    input  logic                          blk_ret_tvalid,
    output logic                          blk_ret_tready,
    input  axis_stream_pkg::stream_beat_t byp_ret_beat,
    input  logic                          byp_ret_tvalid,
    output logic                          byp_ret_tready,
    input  logic                          blk_busy,
    output axis_stream_pkg::stream_beat_t out_beat,
    output logic                          out_tvalid,
    input  logic                          out_tready
);

    axis_ctrl_pkg::ctrl_state_t state_q;
    axis_ctrl_pkg::ctrl_state_t state_d;
    axis_ctrl_pkg::path_sel_t   sel_q;
    axis_ctrl_pkg::path_sel_t   cur_path;
    axis_ctrl_pkg::path_sel_t   req_path;
    logic                       accept_en;
    logic                       in_xfer;
    logic                       paths_empty;
    logic                       out_byp;

    assign req_path    = bypass ? axis_ctrl_pkg::path_bypass : axis_ctrl_pkg::path_block;
    assign paths_empty = !blk_ret_tvalid && !blk_busy && !byp_ret_tvalid;

    // ==================================================
    // Input side
    // ==================================================

    // A path change must wait at a boundary until both paths drain
    always_comb begin
        accept_en = 1'b1;
        cur_path  = sel_q;
        case (state_q)
            axis_ctrl_pkg::st_idle:   cur_path = req_path;
            axis_ctrl_pkg::st_packet: accept_en = 1'b1;
            axis_ctrl_pkg::st_drain:  accept_en = (req_path == sel_q);
            default:                  accept_en = 1'b0;
        endcase
    end

    assign blk_beat   = in_beat;
    assign byp_beat   = in_beat;
    assign blk_tvalid = in_tvalid && accept_en && (cur_path == axis_ctrl_pkg::path_block);
    assign byp_tvalid = in_tvalid && accept_en && (cur_path == axis_ctrl_pkg::path_bypass);
    assign in_tready  = accept_en &&
                        ((cur_path == axis_ctrl_pkg::path_bypass) ? byp_tready : blk_tready);
    assign in_xfer    = in_tvalid && in_tready;

    // tlast on an accepted beat marks the next start of packet
    always_comb begin
        state_d = state_q;
        if (in_xfer) begin
            state_d = in_beat.tlast ? axis_ctrl_pkg::st_drain : axis_ctrl_pkg::st_packet;
        end else if (state_q == axis_ctrl_pkg::st_drain && paths_empty) begin
            state_d = axis_ctrl_pkg::st_idle;
        end
    end

    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= axis_ctrl_pkg::st_idle;
            sel_q   <= axis_ctrl_pkg::path_block;
        end else begin
            state_q <= state_d;
            if (in_xfer) begin
                sel_q <= cur_path;
            end
        end
    end

    // ==================================================
    // Output side
    // ==================================================

    // Only the latched path can hold beats
    assign out_byp        = (sel_q == axis_ctrl_pkg::path_bypass);
    assign out_beat       = out_byp ? byp_ret_beat : blk_ret_beat;
    assign out_tvalid     = out_byp ? byp_ret_tvalid : blk_ret_tvalid;
    assign byp_ret_tready = out_byp && out_tready;
    assign blk_ret_tready = !out_byp && out_tready;

endmodule : axis_path_ctrl

// ==== rtl/axis_reg_slice.sv ====
// Single-stage valid/ready register slice
`timescale 1ns/1ps

module axis_reg_slice (
    input  logic                          axi4s_if_from_tx,
    input  logic                          aresetn,
    input  axis_stream_pkg::stream_beat_t in_beat,
    input  logic                          in_tvalid,
    output logic                          in_tready,
    output axis_stream_pkg::stream_beat_t out_beat,
    output logic                          out_tvalid,
    input  logic                          out_tready
);

    logic                          valid_q;
    axis_stream_pkg::stream_beat_t beat_q;
    logic                          load;

    // Empty, or the held beat leaves this cycle
    assign in_tready = !valid_q || out_tready;
    assign load      = in_tvalid && in_tready;

    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (out_tready) begin
            valid_q <= 1'b0;
        end
    end

    // Payload register
    always_ff @(posedge axi4s_if_from_tx) begin
        if (load) begin
            beat_q <= in_beat;
        end
    end

    assign out_tvalid = valid_q;
    assign out_beat   = beat_q;

endmodule : axis_reg_slice

// ==== rtl/axis_skid_buffer.sv ====
// Input skid buffer with registered upstream ready and first-word fall-through
`timescale 1ns/1ps

module axis_skid_buffer (
    input  logic                          axi4s_if_from_tx,
    input  logic                          aresetn,
    input  axis_stream_pkg::stream_beat_t in_beat,
    input  logic                          in_tvalid,
    output logic                          in_tready,
    output axis_stream_pkg::stream_beat_t out_beat,
    output logic                          out_tvalid,
    input  logic                          out_tready
);

    logic                          out_tready_q;
    logic                          hold_valid;
    axis_stream_pkg::stream_beat_t hold_beat;
    logic                          fwft;
    logic                          tready_falling;
    logic                          sample_en;

    // Downstream ready, one cycle late
    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            out_tready_q <= 1'b0;
        end else begin
            out_tready_q <= out_tready;
        end
    end

    // First beat may enter while downstream was stalled and sample is free
    assign fwft           = in_tvalid && !hold_valid && !out_tready_q;
    assign tready_falling = out_tready_q && !out_tready;

    // Capture the beat in flight when downstream stops taking it
    assign sample_en = tready_falling || (fwft && !out_tready);

    assign in_tready = out_tready_q || fwft;

    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            hold_valid <= 1'b0;
        end else if (out_tready && hold_valid) begin
            hold_valid <= 1'b0;
        end else if (sample_en) begin
            hold_valid <= in_tvalid;
        end
    end

    always_ff @(posedge axi4s_if_from_tx) begin
        if (sample_en) begin
            hold_beat <= in_beat;
        end
    end

    // Sample register wins over the live input
    always_comb begin
        if (hold_valid) begin
            out_tvalid = 1'b1;
            out_beat   = hold_beat;
        end else begin
            out_tvalid = in_tvalid;
            out_beat   = in_beat;
        end
    end

endmodule : axis_skid_buffer

// ==== rtl/axis_stream_pkg.sv ====
// Stream beat layout shared by every datapath block and the testbench
package axis_stream_pkg;

    // ==================================================
    // Beat widths
    // ==================================================

    // Bytes carried per beat
    localparam int data_bytes = 8;
    localparam int data_width = data_bytes * 8;

    // ==================================================
    // Beat payload
    // ==================================================

    // One AXI4-Stream beat, handshake kept beside it
    typedef struct packed {
        logic [data_width-1:0] tdata;
        logic [data_bytes-1:0] tkeep;
        logic                  tlast;
    } stream_beat_t;

endpackage : axis_stream_pkg

// ==== rtl/axis_tlast_advance.sv ====
// Drops the zero-keep trailing beat left by packet joining and moves tlast forward
`timescale 1ns/1ps

module axis_tlast_advance (
    input  logic                          axi4s_if_from_tx,
    input  logic                          aresetn,
    input  axis_stream_pkg::stream_beat_t in_beat,
    input  logic                          in_tvalid,
    output logic                          in_tready,
    output axis_stream_pkg::stream_beat_t out_beat,
    output logic                          out_tvalid,
    input  logic                          out_tready,
    output logic                          busy
);

    logic                          first_q;
    logic                          skip_q;
    logic                          adv_tlast;
    logic                          release_en;
    logic                          slice_in_tvalid;
    logic                          slice_in_tready;
    axis_stream_pkg::stream_beat_t slice_out_beat;
    logic                          slice_out_tvalid;
    logic                          slice_out_tready;

    // Empty trailing beat, never the first beat of its packet
    assign adv_tlast = in_tvalid && in_beat.tlast && (in_beat.tkeep == '0) && !first_q;

    // Dropped beat never enters the slice
    assign slice_in_tvalid = in_tvalid && !adv_tlast;
    assign in_tready       = slice_in_tready;

    axis_reg_slice u_slice (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_beat          (in_beat),
        .in_tvalid        (slice_in_tvalid),
        .in_tready        (slice_in_tready),
        .out_beat         (slice_out_beat),
        .out_tvalid       (slice_out_tvalid),
        .out_tready       (slice_out_tready)
    );

    // Held beat waits for its successor unless it already ends the packet
    assign release_en       = !skip_q || in_tvalid;
    assign slice_out_tready = out_tready && release_en;
    assign out_tvalid       = slice_out_tvalid && release_en;
    assign busy             = slice_out_tvalid;

    always_comb begin
        out_beat       = slice_out_beat;
        out_beat.tlast = slice_out_beat.tlast || adv_tlast;
    end

    // Start of packet, from accepted beats
    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            first_q <= 1'b1;
        end else if (in_tvalid && in_tready) begin
            first_q <= in_beat.tlast;
        end
    end

    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            skip_q <= 1'b0;
        end else if (slice_in_tvalid && slice_in_tready) begin
            skip_q <= !in_beat.tlast;
        end else if (slice_out_tvalid && slice_out_tready) begin
            skip_q <= 1'b0;
        end
    end

endmodule : axis_tlast_advance
